/* verilog/vuart_settings.svh */
// vuart address map and constants
`ifndef VUART_SETTINGS_SVH
`define VUART_SETTINGS_SVH

// ------------------------------------------------------------
// address map
// ------------------------------------------------------------
`define VUART_UART_BASE    12'h200        // uart region, header sits below
`define VUART_FEATURE_ID   32'h0001_0024  // header word value

// ------------------------------------------------------------
// interrupt message and uart defaults
// ------------------------------------------------------------
`define VUART_MSIX_ADDR    20'h40010
`define VUART_MSIX_VECTOR  32'd5
`define VUART_PEND_DEPTH   4              // max undelivered events
`define VUART_DIV_RESET    16'd15         // bit period minus one

`endif

/* verilog/vuart_pkg.sv */
// vuart shared types
package vuart_pkg;

   // ------------------------------------------------------------
   // uart register word offsets
   // ------------------------------------------------------------
   typedef enum logic [1:0] {
      UART_THR = 2'd0,   // data byte, write only
      UART_LSR = 2'd1,   // bit0 busy
      UART_IER = 2'd2,   // bit0 interrupt enable
      UART_DIV = 2'd3    // bit period minus one
   } uart_reg_e;

   // transmitter frame phases
   typedef enum logic [1:0] {
      TX_IDLE  = 2'd0,
      TX_START = 2'd1,
      TX_DATA  = 2'd2,
      TX_STOP  = 2'd3
   } tx_state_e;

   // interrupt message master
   typedef enum logic {
      MSIX_IDLE  = 1'b0,
      MSIX_WRITE = 1'b1
   } msix_state_e;

endpackage

/* verilog/vuart_csr_if.sv */
// internal register access bus
`timescale 1ns/1ps

interface vuart_csr_if;

   logic        req;     // single cycle strobe
   logic        we;
   logic [7:0]  addr;    // byte offset inside the region
   logic [31:0] wdata;
   logic [31:0] rdata;   // combinational, valid with req

   modport host (
      output req,
      output we,
      output addr,
      output wdata,
      input  rdata
   );

   modport dev (
      input  req,
      input  we,
      input  addr,
      input  wdata,
      output rdata
   );

endinterface

/* verilog/vuart_csr_decode.sv */
// wishbone slave and region decoder
`timescale 1ns/1ps
`include "vuart_settings.svh"

module vuart_csr_decode (
   input  logic        clk_csr,
   input  logic        rst_n_csr,
   input  logic        wb_cyc,
   input  logic        wb_stb,
   input  logic        wb_we,
   input  logic [11:0] wb_adr,
   input  logic [31:0] wb_wdata,
   output logic [31:0] wb_rdata,
   output logic        wb_ack,
   vuart_csr_if.host   dfh,
   vuart_csr_if.host   uart
);

   localparam logic [11:0] UART_BASE = `VUART_UART_BASE;

   logic access;
   logic dfh_sel;
   logic uart_sel;

   // ------------------------------------------------------------
   // access and region select
   // ------------------------------------------------------------
   assign access   = wb_cyc & wb_stb & ~wb_ack;   // no new strobe while acking
   // header block decodes 8 bits, 0x100-0x1ff stays unmapped
   assign dfh_sel  = (wb_adr[11:8] == 4'h0);
   assign uart_sel = (wb_adr[11:8] == UART_BASE[11:8]);

   assign dfh.req    = access & dfh_sel;
   assign dfh.we     = wb_we;
   assign dfh.addr   = wb_adr[7:0];
   assign dfh.wdata  = wb_wdata;

   assign uart.req   = access & uart_sel;
   assign uart.we    = wb_we;
   assign uart.addr  = wb_adr[7:0];
   assign uart.wdata = wb_wdata;

   // ------------------------------------------------------------
   // response, one cycle after the strobe is sampled
   // ------------------------------------------------------------
   always_ff @(posedge clk_csr) begin
      if (!rst_n_csr) begin
         wb_ack <= 1'b0;
      end else begin
         wb_ack <= access;
      end
   end

   always_ff @(posedge clk_csr) begin
      if (dfh_sel) begin
         wb_rdata <= dfh.rdata;
      end else if (uart_sel) begin
         wb_rdata <= uart.rdata;
      end else begin
         wb_rdata <= 32'd0;   // unmapped
      end
   end

endmodule

/* verilog/vuart_dfh.sv */
// device feature header block
`timescale 1ns/1ps
`include "vuart_settings.svh"

module vuart_dfh (
   input  logic       clk_csr,
   input  logic       rst_n_csr,
   vuart_csr_if.dev   bus
);

   localparam logic [7:0] OFS_HEADER  = 8'h00;
   localparam logic [7:0] OFS_SCRATCH = 8'h08;

   logic [31:0] scratch;

   // read side, same cycle as req
   always_comb begin
      case (bus.addr)
         OFS_HEADER:  bus.rdata = `VUART_FEATURE_ID;
         OFS_SCRATCH: bus.rdata = scratch;
         default:     bus.rdata = 32'd0;
      endcase
   end

   // header word is constant, only scratch takes writes
   always_ff @(posedge clk_csr) begin
      if (!rst_n_csr) begin
         scratch <= 32'd0;
      end else if (bus.req && bus.we && bus.addr == OFS_SCRATCH) begin
         scratch <= bus.wdata;
      end
   end

endmodule

/* verilog/vuart_tx.sv */
// uart transmitter with register block
`timescale 1ns/1ps
`include "vuart_settings.svh"

module vuart_tx
   import vuart_pkg::*;
(
   input  logic       clk_csr,
   input  logic       rst_n_csr,
   vuart_csr_if.dev   bus,
   output logic       tx,
   output logic       tx_done
);

   tx_state_e   state;
   uart_reg_e   reg_sel;
   logic        mapped;
   logic        wr;
   logic        start;
   logic        busy;
   logic        bit_end;
   logic        ier;
   logic [15:0] div;
   logic [15:0] timer;
   logic [2:0]  bit_cnt;
   logic [7:0]  shift;

   // ------------------------------------------------------------
   // register access
   // ------------------------------------------------------------
   assign mapped  = (bus.addr[7:4] == 4'h0);
   assign reg_sel = uart_reg_e'(bus.addr[3:2]);
   assign wr      = bus.req & bus.we & mapped;
   assign start   = wr & (reg_sel == UART_THR) & ~busy;   // thr ignored while busy
   assign busy    = (state != TX_IDLE);

   always_comb begin
      bus.rdata = 32'd0;
      if (mapped) begin
         case (reg_sel)
            UART_LSR: bus.rdata = {31'd0, busy};
            UART_IER: bus.rdata = {31'd0, ier};
            UART_DIV: bus.rdata = {16'd0, div};
            default:  bus.rdata = 32'd0;   // thr reads zero
         endcase
      end
   end

   always_ff @(posedge clk_csr) begin
      if (!rst_n_csr) begin
         ier <= 1'b0;
         div <= `VUART_DIV_RESET;
      end else if (wr) begin
         if (reg_sel == UART_IER) ier <= bus.wdata[0];
         if (reg_sel == UART_DIV) div <= bus.wdata[15:0];
      end
   end

   // ------------------------------------------------------------
   // frame sequencer
   // ------------------------------------------------------------
   assign bit_end = (timer == div);   // div+1 clocks per bit

   always_ff @(posedge clk_csr) begin
      if (!rst_n_csr) begin
         state   <= TX_IDLE;
         timer   <= 16'd0;
         bit_cnt <= 3'd0;
         tx_done <= 1'b0;
      end else begin
         tx_done <= 1'b0;
         if (state == TX_IDLE || bit_end) begin
            timer <= 16'd0;
         end else begin
            timer <= timer + 16'd1;
         end
         case (state)
            TX_IDLE: begin
               if (start) state <= TX_START;
            end
            TX_START: begin
               if (bit_end) begin
                  state   <= TX_DATA;
                  bit_cnt <= 3'd0;
               end
            end
            TX_DATA: begin
               if (bit_end) begin
                  bit_cnt <= bit_cnt + 3'd1;
                  if (bit_cnt == 3'd7) state <= TX_STOP;
               end
            end
            default: begin   // stop bit
               if (bit_end) begin
                  state   <= TX_IDLE;
                  tx_done <= ier;   // event only with interrupts on
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk_csr) begin
      if (start) begin
         shift <= bus.wdata[7:0];
      end else if (state == TX_DATA && bit_end) begin
         shift <= {1'b0, shift[7:1]};   // lsb first
      end
   end

   always_comb begin
      case (state)
         TX_START: tx = 1'b0;
         TX_DATA:  tx = shift[0];
         default:  tx = 1'b1;   // idle and stop are mark
      endcase
   end

endmodule

/* verilog/vuart_irq_pending.sv */
// pending interrupt event counter
`timescale 1ns/1ps
`include "vuart_settings.svh"

module vuart_irq_pending (
   input  logic clk_csr,
   input  logic rst_n_csr,
   input  logic event_in,
   input  logic take,
   output logic pend_valid
);

   localparam int DEPTH = `VUART_PEND_DEPTH;
   localparam int CW    = $clog2(DEPTH + 1);

   logic [CW-1:0] count;
   logic          full;
   logic          inc;
   logic          dec;

   assign full = (count == CW'(DEPTH));
   assign dec  = take & (count != '0);
   // a take frees a slot in the same cycle, so a full counter still nets zero
   assign inc  = event_in & (~full | dec);

   always_ff @(posedge clk_csr) begin
      if (!rst_n_csr) begin
         count <= '0;
      end else begin
         case ({inc, dec})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // idle or both
         endcase
      end
   end

   assign pend_valid = (count != '0);

endmodule

/* verilog/vuart_msix_master.sv */
// wishbone master for interrupt messages
`timescale 1ns/1ps
`include "vuart_settings.svh"

module vuart_msix_master
   import vuart_pkg::*;
(
   input  logic        clk_csr,
   input  logic        rst_n_csr,
   input  logic        pend_valid,
   output logic        pend_take,
   output logic        msix_cyc,
   output logic        msix_stb,
   output logic        msix_we,
   output logic [19:0] msix_adr,
   output logic [31:0] msix_dat,
   input  logic        msix_ack
);

   msix_state_e state;
   logic        active;

   // ------------------------------------------------------------
   // one message per pending event, one idle cycle between them
   // ------------------------------------------------------------
   always_ff @(posedge clk_csr) begin
      if (!rst_n_csr) begin
         state <= MSIX_IDLE;
      end else begin
         case (state)
            MSIX_IDLE:  if (pend_valid) state <= MSIX_WRITE;
            default:    if (msix_ack) state <= MSIX_IDLE;
         endcase
      end
   end

   assign active    = (state == MSIX_WRITE);
   assign pend_take = active & msix_ack;   // consumes one event

   assign msix_cyc  = active;
   assign msix_stb  = active;
   assign msix_we   = active;
   assign msix_adr  = active ? `VUART_MSIX_ADDR : 20'd0;
   assign msix_dat  = active ? `VUART_MSIX_VECTOR : 32'd0;

endmodule

/* verilog/vuart_top.sv */
// virtual uart feature top level
`timescale 1ns/1ps

module vuart_top (
   input  logic        clk_csr,
   input  logic        rst_n_csr,
   // host csr port
   input  logic        wb_cyc,
   input  logic        wb_stb,
   input  logic        wb_we,
   input  logic [11:0] wb_adr,
   input  logic [31:0] wb_wdata,
   output logic [31:0] wb_rdata,
   output logic        wb_ack,
   // interrupt message port
   output logic        msix_cyc,
   output logic        msix_stb,
   output logic        msix_we,
   output logic [19:0] msix_adr,
   output logic [31:0] msix_dat,
   input  logic        msix_ack,
   // serial line
   output logic        tx
);

   logic tx_done;
   logic pend_valid;
   logic pend_take;

   vuart_csr_if dfh_bus ();
   vuart_csr_if uart_bus ();

   // ------------------------------------------------------------
   // csr side
   // ------------------------------------------------------------
   vuart_csr_decode i_decode (
      .clk_csr   (clk_csr),
      .rst_n_csr (rst_n_csr),
      .wb_cyc    (wb_cyc),
      .wb_stb    (wb_stb),
      .wb_we     (wb_we),
      .wb_adr    (wb_adr),
      .wb_wdata  (wb_wdata),
      .wb_rdata  (wb_rdata),
      .wb_ack    (wb_ack),
      .dfh       (dfh_bus.host),
      .uart      (uart_bus.host)
   );

   vuart_dfh i_dfh (
      .clk_csr   (clk_csr),
      .rst_n_csr (rst_n_csr),
      .bus       (dfh_bus.dev)
   );

   vuart_tx i_tx (
      .clk_csr   (clk_csr),
      .rst_n_csr (rst_n_csr),
      .bus       (uart_bus.dev),
      .tx        (tx),
      .tx_done   (tx_done)
   );

   // ------------------------------------------------------------
   // interrupt path, event -> pending -> message
   // ------------------------------------------------------------
   vuart_irq_pending i_pending (
      .clk_csr    (clk_csr),
      .rst_n_csr  (rst_n_csr),
      .event_in   (tx_done),
      .take       (pend_take),
      .pend_valid (pend_valid)
   );

   vuart_msix_master i_msix (
      .clk_csr    (clk_csr),
      .rst_n_csr  (rst_n_csr),
      .pend_valid (pend_valid),
      .pend_take  (pend_take),
      .msix_cyc   (msix_cyc),
      .msix_stb   (msix_stb),
      .msix_we    (msix_we),
      .msix_adr   (msix_adr),
      .msix_dat   (msix_dat),
      .msix_ack   (msix_ack)
   );

endmodule

/* bench/vuart_tb.sv */
// virtual uart testbench
`timescale 1ns/1ps
`include "vuart_settings.svh"

module vuart_tb;

   localparam logic [11:0] ADR_THR = `VUART_UART_BASE;
   localparam logic [11:0] ADR_LSR = `VUART_UART_BASE + 12'h004;
   localparam logic [11:0] ADR_IER = `VUART_UART_BASE + 12'h008;
   localparam logic [11:0] ADR_DIV = `VUART_UART_BASE + 12'h00c;

   logic        clk_csr = 1'b0;
   logic        rst_n_csr;
   logic        wb_cyc;
   logic        wb_stb;
   logic        wb_we;
   logic [11:0] wb_adr;
   logic [31:0] wb_wdata;
   logic [31:0] wb_rdata;
   logic        wb_ack;
   logic        msix_cyc;
   logic        msix_stb;
   logic        msix_we;
   logic [19:0] msix_adr;
   logic [31:0] msix_dat;
   logic        msix_ack = 1'b0;
   logic        tx;

   int          errors = 0;
   int          tests = 0;
   int          failed_tests = 0;
   int          test_start_errs = 0;
   string       cur_test = "reset";
   logic [31:0] rng_main = 32'h8624;
   logic [31:0] rng_ack = 32'h8624;   // own stream for the slave delays
   logic [2:0]  ack_wait = 3'd0;
   logic        msg_open = 1'b0;
   logic        stall = 1'b0;
   int          msg_cnt = 0;
   int          mon_div = 3;
   logic        tx_prev = 1'b1;
   logic [7:0]  rx_byte;
   logic [7:0]  rx_q[$];

   always #10 clk_csr = ~clk_csr;

   vuart_top i_dut (.*);

   // ------------------------------------------------------------
   // helpers
   // ------------------------------------------------------------
   function automatic logic [31:0] xorshift(input logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   task automatic check_val(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
      assert (actual === expected) else begin
         $display("Mismatch %s %s: expected %h, actual %h", cur_test, what, expected, actual);
         errors++;
      end
   endtask

   task automatic report_failure(input string msg);
      $display("%s: %s", cur_test, msg);
      errors++;
   endtask

   task automatic begin_test(input string name);
      cur_test = name;
      test_start_errs = errors;
   endtask

   task automatic end_test;
      tests++;
      if (errors > test_start_errs) failed_tests++;
      $display("test %s finished with %0d errors", cur_test, errors - test_start_errs);
   endtask

   // one classic cycle with ack expected at the second sampled edge
   task automatic wb_access(input logic we, input logic [11:0] adr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
      int cycles;
      cycles = 0;
      @(posedge clk_csr);
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      wb_we    <= we;
      wb_adr   <= adr;
      wb_wdata <= wdata;
      do begin
         @(posedge clk_csr);
         cycles++;
      end while (!wb_ack && cycles < 16);
      if (!wb_ack) begin
         report_failure($sformatf("timeout waiting for wb_ack at address %h", adr));
      end else begin
         check_val("ack latency", 32'd2, cycles);
      end
      rdata = wb_rdata;
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
   endtask

   task automatic wb_write(input logic [11:0] adr, input logic [31:0] wdata);
      logic [31:0] unused;
      wb_access(1'b1, adr, wdata, unused);
   endtask

   task automatic wb_read(input logic [11:0] adr, output logic [31:0] rdata);
      wb_access(1'b0, adr, 32'd0, rdata);
   endtask

   task automatic wait_frames(input int target);
      int cycles;
      cycles = 0;
      while (rx_q.size() < target && cycles < 400) begin
         @(posedge clk_csr);
         cycles++;
      end
      if (rx_q.size() < target) report_failure("timeout waiting for a serial frame");
   endtask

   task automatic wait_idle;
      logic [31:0] lsr;
      int tries;
      tries = 0;
      lsr = 32'd1;
      while (lsr[0] && tries < 100) begin
         wb_read(ADR_LSR, lsr);
         tries++;
      end
      if (lsr[0]) report_failure("transmitter stayed busy");
   endtask

   task automatic wait_msgs(input int target);
      int cycles;
      cycles = 0;
      while (msg_cnt < target && cycles < 400) begin
         @(posedge clk_csr);
         cycles++;
      end
      if (msg_cnt < target) report_failure("timeout waiting for interrupt messages");
   endtask

   task automatic send_frame(input logic [7:0] b);
      int n;
      n = rx_q.size();
      wb_write(ADR_THR, {24'd0, b});
      wait_frames(n + 1);
      if (rx_q.size() > n) check_val("serial byte", {24'd0, b}, {24'd0, rx_q[n]});
      wait_idle;
      check_val("tx idle level", 32'd1, {31'd0, tx});
   endtask

   // ------------------------------------------------------------
   // msix slave model with random ack delay
   // ------------------------------------------------------------
   always @(posedge clk_csr) begin
      if (!rst_n_csr) begin
         msix_ack <= 1'b0;
         msg_open <= 1'b0;
         ack_wait <= 3'd0;
      end else begin
         msix_ack <= 1'b0;
         if (msix_cyc && msix_stb && !msix_ack) begin
            if (!msg_open) begin
               msg_open <= 1'b1;
               ack_wait <= rng_ack[2:0];
               rng_ack  <= xorshift(rng_ack);
            end else if (ack_wait != 3'd0) begin
               ack_wait <= ack_wait - 3'd1;
            end else if (!stall) begin
               msix_ack <= 1'b1;
               msg_open <= 1'b0;
               msg_cnt  <= msg_cnt + 1;
               check_val("msix we", 32'd1, {31'd0, msix_we});
               check_val("msix address", {12'd0, `VUART_MSIX_ADDR}, {12'd0, msix_adr});
               check_val("msix vector", `VUART_MSIX_VECTOR, msix_dat);
            end
         end
      end
   end

   // serial monitor samples near the middle of each bit
   always begin
      @(posedge clk_csr);
      if (rst_n_csr && tx_prev === 1'b1 && tx === 1'b0) begin
         repeat (mon_div / 2) @(posedge clk_csr);
         check_val("start bit", 32'd0, {31'd0, tx});
         for (int i = 0; i < 8; i++) begin
            repeat (mon_div + 1) @(posedge clk_csr);
            rx_byte[i] = tx;   // lsb first
         end
         repeat (mon_div + 1) @(posedge clk_csr);
         check_val("stop bit", 32'd1, {31'd0, tx});
         rx_q.push_back(rx_byte);
      end
      tx_prev = tx;
   end

   // ------------------------------------------------------------
   // bus protocol properties
   // ------------------------------------------------------------
   ack_one_cycle: assert property (@(posedge clk_csr) disable iff (!rst_n_csr)
      wb_ack |=> !wb_ack)
      else report_failure("wb_ack stayed high for more than one cycle");

   msix_hold: assert property (@(posedge clk_csr) disable iff (!rst_n_csr)
      (msix_cyc && !msix_ack) |=> (msix_cyc && msix_stb && msix_we
                                   && $stable(msix_adr) && $stable(msix_dat)))
      else report_failure("msix request changed before ack");

   msix_release: assert property (@(posedge clk_csr) disable iff (!rst_n_csr)
      msix_ack |=> (!msix_cyc && !msix_stb))
      else report_failure("msix cycle not dropped after ack");

   // ------------------------------------------------------------
   // test sequence
   // ------------------------------------------------------------
   initial begin
      logic [31:0] rd;
      logic [31:0] w;
      logic [7:0]  b;
      int          n;
      int          base;
      rst_n_csr = 1'b0;
      wb_cyc    = 1'b0;
      wb_stb    = 1'b0;
      wb_we     = 1'b0;
      wb_adr    = 12'd0;
      wb_wdata  = 32'd0;
      repeat (3) @(posedge clk_csr);
      rst_n_csr <= 1'b1;

      begin_test("feature_header");
      wb_read(12'h000, rd);
      check_val("header word", `VUART_FEATURE_ID, rd);
      wb_write(12'h000, 32'hdead_beef);
      wb_read(12'h000, rd);
      check_val("header after write", `VUART_FEATURE_ID, rd);
      for (int k = 0; k < 2; k++) begin
         rng_main = xorshift(rng_main);
         w = rng_main;
         wb_write(12'h008, w);
         wb_read(12'h008, rd);
         check_val("scratch", w, rd);
      end
      wb_read(12'h100, rd);
      check_val("unmapped read", 32'd0, rd);
      end_test;

      begin_test("register_access");
      check_val("tx after reset", 32'd1, {31'd0, tx});
      check_val("msix_cyc after reset", 32'd0, {31'd0, msix_cyc});
      wb_read(ADR_IER, rd);
      check_val("ier reset", 32'd0, rd);
      wb_read(ADR_DIV, rd);
      check_val("div reset", {16'd0, `VUART_DIV_RESET}, rd);
      wb_write(ADR_IER, 32'd1);
      wb_read(ADR_IER, rd);
      check_val("ier set", 32'd1, rd);
      wb_write(ADR_IER, 32'd0);
      wb_read(ADR_IER, rd);
      check_val("ier clear", 32'd0, rd);
      wb_write(ADR_DIV, 32'd3);
      mon_div = 3;
      wb_read(ADR_DIV, rd);
      check_val("div", 32'd3, rd);
      end_test;

      begin_test("serial_frame");
      for (int k = 0; k < 3; k++) begin
         rng_main = xorshift(rng_main);
         send_frame(rng_main[7:0]);
      end
      end_test;

      begin_test("busy_handling");
      rng_main = xorshift(rng_main);
      b = rng_main[7:0];
      n = rx_q.size();
      wb_write(ADR_THR, {24'd0, b});
      wb_read(ADR_LSR, rd);
      check_val("busy during frame", 32'd1, rd);
      wb_write(ADR_THR, {24'd0, ~b});   // dropped while the frame is in flight
      wait_frames(n + 1);
      if (rx_q.size() > n) check_val("serial byte", {24'd0, b}, {24'd0, rx_q[n]});
      wait_idle;
      wb_read(ADR_LSR, rd);
      check_val("busy after frame", 32'd0, rd);
      repeat (60) @(posedge clk_csr);
      check_val("frame count", n + 1, rx_q.size());
      end_test;

      begin_test("interrupt_messages");
      base = msg_cnt;
      wb_write(ADR_IER, 32'd1);
      for (int k = 0; k < 3; k++) begin
         rng_main = xorshift(rng_main);
         send_frame(rng_main[7:0]);
      end
      wait_msgs(base + 3);
      repeat (30) @(posedge clk_csr);
      check_val("message count", base + 3, msg_cnt);
      base = msg_cnt;
      wb_write(ADR_IER, 32'd0);
      send_frame(8'h5a);
      repeat (30) @(posedge clk_csr);
      check_val("messages with ier off", base, msg_cnt);
      end_test;

      begin_test("back_pressure");
      base = msg_cnt;
      wb_write(ADR_IER, 32'd1);
      stall <= 1'b1;
      for (int k = 0; k < 6; k++) begin
         rng_main = xorshift(rng_main);
         send_frame(rng_main[7:0]);
      end
      check_val("request held while stalled", 32'd1, {31'd0, msix_cyc});
      stall <= 1'b0;
      wait_msgs(base + `VUART_PEND_DEPTH);
      repeat (60) @(posedge clk_csr);
      check_val("messages after release", base + `VUART_PEND_DEPTH, msg_cnt);
      check_val("msix bus idle", 32'd0, {31'd0, msix_cyc});
      end_test;

      $display("%0d tests run, %0d with errors, %0d errors in total",
               tests, failed_tests, errors);
      if (errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

/* sources.f */
+incdir+verilog
verilog/vuart_pkg.sv
verilog/vuart_csr_if.sv
verilog/vuart_csr_decode.sv
verilog/vuart_dfh.sv
verilog/vuart_tx.sv
verilog/vuart_irq_pending.sv
verilog/vuart_msix_master.sv
verilog/vuart_top.sv
bench/vuart_tb.sv
